// File: hw/ap_fetch_defs.svh
`ifndef AP_FETCH_DEFS_SVH
`define AP_FETCH_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word and address widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AP_ISA_WIDTH        30
`define AP_ADDR_WIDTH       16
`define AP_DDR_ADDR_WIDTH   28
`define AP_LEN_WIDTH        10
`define AP_WORD_BYTES       8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Storage depths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AP_WINDOW_DEPTH     128
`define AP_WINDOW_IDX_WIDTH $clog2(`AP_WINDOW_DEPTH)
`define AP_PROGRAM_DEPTH    300
`define AP_ISR_DEPTH        16
`define AP_ISR_ADDR_WIDTH   $clog2(`AP_ISR_DEPTH)

`endif

// File: hw/ap_fetch_pkg.sv
`include "ap_fetch_defs.svh"

package ap_fetch_pkg;

    // Opcode codes, gaps are illegal.
    typedef enum logic [3:0] {
        reset     = 4'd1,
        ret       = 4'd2,
        load_rbr  = 4'd4,
        load_cbc  = 4'd5,
        store_rbr = 4'd6,
        store_cbc = 4'd7,
        copy      = 4'd8,
        add       = 4'd9,
        sub       = 4'd10,
        tsc       = 4'd11,
        abs       = 4'd12
    } opcode_t;

    typedef enum logic [1:0] {
        none = 2'd0,
        m_a  = 2'd1,
        m_b  = 2'd2,
        m_r  = 2'd3
    } operand_mode_t;

    typedef enum logic [1:0] {
        mem_op     = 2'd0,
        row_op     = 2'd1,
        ctrl_op    = 2'd2,
        illegal_op = 2'd3
    } op_class_t;

    // Memory transfers carry a full program address in the low half.
    typedef struct packed {
        opcode_t                   opcode;
        logic [7:0]                cam_addr;
        operand_mode_t             mode;
        logic [`AP_ADDR_WIDTH-1:0] mem_addr;
    } isa_mem_t;

    // Row operations split the low half into a source row and a count.
    typedef struct packed {
        opcode_t       opcode;
        logic [7:0]    cam_addr;
        operand_mode_t mode;
        logic [7:0]    src_row;
        logic [7:0]    count;
    } isa_row_t;

    typedef union packed {
        isa_mem_t mem;
        isa_row_t row;
    } isa_word_t;

endpackage

// File: hw/ins_cache.sv
`include "ap_fetch_defs.svh"

module ins_cache
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch,
    input  logic [`AP_ADDR_WIDTH-1:0]     addr_ins,
    input  ap_fetch_pkg::isa_word_t       instruction_to_cache,
    input  logic [`AP_LEN_WIDTH-1:0]      rd_cnt_isa,
    input  logic                          rd_burst_data_valid,
    output logic                          ins_cache_rdy,
    output logic                          isa_read_req,
    output logic [`AP_DDR_ADDR_WIDTH-1:0] isa_read_addr,
    output logic [`AP_LEN_WIDTH-1:0]      isa_read_len,
    output logic [`AP_LEN_WIDTH-1:0]      load_times,
    output logic                          cache_hit,
    output ap_fetch_pkg::isa_word_t       cache_word
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_load  = 2'd1;
    localparam logic [1:0] st_serve = 2'd2;

    ap_fetch_pkg::isa_word_t window [0:`AP_WINDOW_DEPTH-1];

    logic [1:0]                          state;
    logic [`AP_ADDR_WIDTH-1:0]           tag;
    logic [`AP_LEN_WIDTH-1:0]            loaded_len;
    logic                                valid;

    logic                                lookup;
    logic                                in_window;
    logic [`AP_ADDR_WIDTH-1:0]           offset;
    logic [`AP_ADDR_WIDTH-1:0]           remaining;
    logic [`AP_LEN_WIDTH-1:0]            new_len;
    logic [`AP_DDR_ADDR_WIDTH-1:0]       addr_ext;
    logic [`AP_LEN_WIDTH-1:0]            beat_idx;
    logic [`AP_WINDOW_IDX_WIDTH-1:0]     rd_idx;
    logic                                burst_done;
    logic                                hit_pend;
    logic [`AP_WINDOW_IDX_WIDTH-1:0]     hit_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window lookup.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lookup = (state == st_idle) && fetch && !addr_ins[`AP_ADDR_WIDTH-1];
    assign offset = addr_ins - tag;
    assign in_window = valid && (addr_ins >= tag)
        && (offset < {{(`AP_ADDR_WIDTH-`AP_LEN_WIDTH){1'b0}}, loaded_len});

    // New window starts at the fetch address and is cut at the program end.
    assign remaining = `AP_ADDR_WIDTH'(`AP_PROGRAM_DEPTH) - addr_ins;
    assign new_len = (remaining < `AP_ADDR_WIDTH'(`AP_WINDOW_DEPTH))
        ? remaining[`AP_LEN_WIDTH-1:0] : `AP_LEN_WIDTH'(`AP_WINDOW_DEPTH);
    assign addr_ext = {{(`AP_DDR_ADDR_WIDTH-`AP_ADDR_WIDTH){1'b0}}, addr_ins};

    assign beat_idx = rd_cnt_isa - 1'b1;
    assign burst_done = (state == st_load) && rd_burst_data_valid
        && (rd_cnt_isa == isa_read_len);

    // After a load the pending address is the tag itself.
    assign rd_idx = (state == st_serve) ? '0 : hit_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state         <= st_idle;
            tag           <= '0;
            loaded_len    <= '0;
            valid         <= 1'b0;
            ins_cache_rdy <= 1'b1;
            isa_read_req  <= 1'b0;
            isa_read_addr <= '0;
            isa_read_len  <= '0;
            load_times    <= '0;
            cache_hit     <= 1'b0;
            hit_pend      <= 1'b0;
        end
        else
        begin
            // A hit answers one cycle after the lookup.
            cache_hit <= hit_pend;
            hit_pend  <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (lookup && in_window)
                    begin
                        hit_pend <= 1'b1;
                    end
                    else if (lookup)
                    begin
                        state         <= st_load;
                        tag           <= addr_ins;
                        valid         <= 1'b0;
                        ins_cache_rdy <= 1'b0;
                        isa_read_req  <= 1'b1;
                        isa_read_addr <= addr_ext * `AP_DDR_ADDR_WIDTH'(`AP_WORD_BYTES);
                        isa_read_len  <= new_len;
                    end
                end
                st_load:
                begin
                    if (burst_done)
                    begin
                        state        <= st_serve;
                        isa_read_req <= 1'b0;
                        loaded_len   <= isa_read_len;
                        valid        <= 1'b1;
                        load_times   <= load_times + 1'b1;
                    end
                end
                st_serve:
                begin
                    state         <= st_idle;
                    cache_hit     <= 1'b1;
                    ins_cache_rdy <= 1'b1;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Beat k lands at index k-1.
    always_ff @(posedge clk)
    begin
        if ((state == st_load) && rd_burst_data_valid)
        begin
            window[beat_idx[`AP_WINDOW_IDX_WIDTH-1:0]] <= instruction_to_cache;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup && in_window)
        begin
            hit_idx <= offset[`AP_WINDOW_IDX_WIDTH-1:0];
        end
        if (hit_pend || (state == st_serve))
        begin
            cache_word <= window[rd_idx];
        end
    end

endmodule

// File: hw/isr_store.sv
`include "ap_fetch_defs.svh"

module isr_store
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch,
    input  logic [`AP_ADDR_WIDTH-1:0]     addr_ins,
    input  logic                          isr_we,
    input  logic [`AP_ISR_ADDR_WIDTH-1:0] isr_waddr,
    input  ap_fetch_pkg::isa_word_t       isr_wdata,
    output logic                          isr_hit,
    output ap_fetch_pkg::isa_word_t       isr_word
);

    ap_fetch_pkg::isa_word_t entry [0:`AP_ISR_DEPTH-1];

    logic                          isr_fetch;
    logic                          isr_pend;
    logic [`AP_ISR_ADDR_WIDTH-1:0] isr_idx;

    // High half of the program space belongs to the service routines.
    assign isr_fetch = fetch && addr_ins[`AP_ADDR_WIDTH-1];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < `AP_ISR_DEPTH; i++)
            begin
                entry[i] <= '0;
            end
            isr_pend <= 1'b0;
            isr_hit  <= 1'b0;
        end
        else
        begin
            if (isr_we)
            begin
                entry[isr_waddr] <= isr_wdata;
            end
            isr_pend <= isr_fetch;
            isr_hit  <= isr_pend;
        end
    end

    // The entry is read one cycle after the fetch is sampled.
    always_ff @(posedge clk)
    begin
        if (isr_fetch)
        begin
            isr_idx <= addr_ins[`AP_ISR_ADDR_WIDTH-1:0];
        end
        if (isr_pend)
        begin
            isr_word <= entry[isr_idx];
        end
    end

endmodule

// File: hw/ins_issue.sv
`include "ap_fetch_defs.svh"

module ins_issue
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cache_hit,
    input  ap_fetch_pkg::isa_word_t   cache_word,
    input  logic                      isr_hit,
    input  ap_fetch_pkg::isa_word_t   isr_word,
    output ap_fetch_pkg::isa_word_t   instruction,
    output logic                      ins_valid,
    output ap_fetch_pkg::op_class_t   op_class,
    output logic [`AP_ADDR_WIDTH-1:0] mem_addr,
    output logic [7:0]                src_row,
    output logic [7:0]                count,
    output logic                      ill_op
);

    ap_fetch_pkg::isa_word_t   sel_word;
    ap_fetch_pkg::op_class_t   sel_class;
    logic                      sel_valid;
    logic [`AP_ADDR_WIDTH-1:0] dec_mem_addr;
    logic [7:0]                dec_src_row;
    logic [7:0]                dec_count;

    // Only one source answers in any cycle.
    assign sel_valid = cache_hit | isr_hit;
    assign sel_word  = cache_hit ? cache_word : isr_word;

    always_comb
    begin
        dec_mem_addr = '0;
        dec_src_row  = '0;
        dec_count    = '0;
        case (sel_word.mem.opcode)
            ap_fetch_pkg::load_rbr, ap_fetch_pkg::load_cbc,
            ap_fetch_pkg::store_rbr, ap_fetch_pkg::store_cbc:
            begin
                sel_class    = ap_fetch_pkg::mem_op;
                dec_mem_addr = sel_word.mem.mem_addr;
            end
            ap_fetch_pkg::copy, ap_fetch_pkg::add, ap_fetch_pkg::sub,
            ap_fetch_pkg::tsc, ap_fetch_pkg::abs:
            begin
                sel_class   = ap_fetch_pkg::row_op;
                dec_src_row = sel_word.row.src_row;
                dec_count   = sel_word.row.count;
            end
            ap_fetch_pkg::reset, ap_fetch_pkg::ret:
            begin
                sel_class = ap_fetch_pkg::ctrl_op;
            end
            default:
            begin
                sel_class = ap_fetch_pkg::illegal_op;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ins_valid <= 1'b0;
            ill_op    <= 1'b0;
        end
        else
        begin
            ins_valid <= sel_valid;
            ill_op    <= sel_valid && (sel_class == ap_fetch_pkg::illegal_op);
        end
    end

    always_ff @(posedge clk)
    begin
        if (sel_valid)
        begin
            instruction <= sel_word;
            op_class    <= sel_class;
            mem_addr    <= dec_mem_addr;
            src_row     <= dec_src_row;
            count       <= dec_count;
        end
    end

endmodule

// File: hw/ap_fetch_top.sv
`include "ap_fetch_defs.svh"

module ap_fetch_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch,
    input  logic [`AP_ADDR_WIDTH-1:0]     addr_ins,
    output logic                          ins_cache_rdy,
    output logic [`AP_LEN_WIDTH-1:0]      load_times,
    output logic                          isa_read_req,
    output logic [`AP_DDR_ADDR_WIDTH-1:0] isa_read_addr,
    output logic [`AP_LEN_WIDTH-1:0]      isa_read_len,
    input  ap_fetch_pkg::isa_word_t       instruction_to_cache,
    input  logic [`AP_LEN_WIDTH-1:0]      rd_cnt_isa,
    input  logic                          rd_burst_data_valid,
    input  logic                          isr_we,
    input  logic [`AP_ISR_ADDR_WIDTH-1:0] isr_waddr,
    input  ap_fetch_pkg::isa_word_t       isr_wdata,
    output ap_fetch_pkg::isa_word_t       instruction,
    output logic                          ins_valid,
    output ap_fetch_pkg::op_class_t       op_class,
    output logic [`AP_ADDR_WIDTH-1:0]     mem_addr,
    output logic [7:0]                    src_row,
    output logic [7:0]                    count,
    output logic                          ill_op
);

    logic                    cache_hit;
    ap_fetch_pkg::isa_word_t cache_word;
    logic                    isr_hit;
    ap_fetch_pkg::isa_word_t isr_word;

    // Both sources see every fetch and pick their own half.
    ins_cache i_ins_cache (
        .clk                  (clk),
        .rst                  (rst),
        .fetch                (fetch),
        .addr_ins             (addr_ins),
        .instruction_to_cache (instruction_to_cache),
        .rd_cnt_isa           (rd_cnt_isa),
        .rd_burst_data_valid  (rd_burst_data_valid),
        .ins_cache_rdy        (ins_cache_rdy),
        .isa_read_req         (isa_read_req),
        .isa_read_addr        (isa_read_addr),
        .isa_read_len         (isa_read_len),
        .load_times           (load_times),
        .cache_hit            (cache_hit),
        .cache_word           (cache_word)
    );

    isr_store i_isr_store (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .addr_ins  (addr_ins),
        .isr_we    (isr_we),
        .isr_waddr (isr_waddr),
        .isr_wdata (isr_wdata),
        .isr_hit   (isr_hit),
        .isr_word  (isr_word)
    );

    ins_issue i_ins_issue (
        .clk         (clk),
        .rst         (rst),
        .cache_hit   (cache_hit),
        .cache_word  (cache_word),
        .isr_hit     (isr_hit),
        .isr_word    (isr_word),
        .instruction (instruction),
        .ins_valid   (ins_valid),
        .op_class    (op_class),
        .mem_addr    (mem_addr),
        .src_row     (src_row),
        .count       (count),
        .ill_op      (ill_op)
    );

endmodule

// File: dv/ddr_isa_model.sv
`include "ap_fetch_defs.svh"

module ddr_isa_model
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          isa_read_req,
    input  logic [`AP_DDR_ADDR_WIDTH-1:0] isa_read_addr,
    input  logic [`AP_LEN_WIDTH-1:0]      isa_read_len,
    output logic                          rd_burst_data_valid,
    output logic [`AP_LEN_WIDTH-1:0]      rd_cnt_isa,
    output ap_fetch_pkg::isa_word_t       instruction_to_cache
);

    // Program image, filled by the testbench before the first burst.
    ap_fetch_pkg::isa_word_t image [0:`AP_PROGRAM_DEPTH-1];

    logic                          active;
    logic                          drain;
    logic [`AP_DDR_ADDR_WIDTH-1:0] base;
    logic [`AP_LEN_WIDTH-1:0]      len;

    // One beat per cycle; after the last beat wait for the request to drop.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            active               <= 1'b0;
            drain                <= 1'b0;
            base                 <= '0;
            len                  <= '0;
            rd_burst_data_valid  <= 1'b0;
            rd_cnt_isa           <= '0;
            instruction_to_cache <= '0;
        end
        else
        begin
            rd_burst_data_valid <= 1'b0;
            if (active)
            begin
                rd_burst_data_valid  <= 1'b1;
                rd_cnt_isa           <= rd_cnt_isa + 1'b1;
                instruction_to_cache <= image[base + rd_cnt_isa];
                if (rd_cnt_isa + 1 == len)
                begin
                    active <= 1'b0;
                    drain  <= 1'b1;
                end
            end
            else if (drain)
            begin
                if (!isa_read_req)
                begin
                    drain <= 1'b0;
                end
            end
            else if (isa_read_req)
            begin
                active     <= 1'b1;
                base       <= isa_read_addr / `AP_WORD_BYTES;
                len        <= isa_read_len;
                rd_cnt_isa <= '0;
            end
        end
    end

endmodule

// File: dv/tb_ap_fetch.sv
`include "ap_fetch_defs.svh"

module tb_ap_fetch;

    localparam int hit_timeout  = 10;
    localparam int load_timeout = 400;

    logic                          clk;
    logic                          rst;
    logic                          fetch;
    logic [`AP_ADDR_WIDTH-1:0]     addr_ins;
    logic                          ins_cache_rdy;
    logic [`AP_LEN_WIDTH-1:0]      load_times;
    logic                          isa_read_req;
    logic [`AP_DDR_ADDR_WIDTH-1:0] isa_read_addr;
    logic [`AP_LEN_WIDTH-1:0]      isa_read_len;
    ap_fetch_pkg::isa_word_t       instruction_to_cache;
    logic [`AP_LEN_WIDTH-1:0]      rd_cnt_isa;
    logic                          rd_burst_data_valid;
    logic                          isr_we;
    logic [`AP_ISR_ADDR_WIDTH-1:0] isr_waddr;
    ap_fetch_pkg::isa_word_t       isr_wdata;
    ap_fetch_pkg::isa_word_t       instruction;
    logic                          ins_valid;
    ap_fetch_pkg::op_class_t       op_class;
    logic [`AP_ADDR_WIDTH-1:0]     mem_addr;
    logic [7:0]                    src_row;
    logic [7:0]                    count;
    logic                          ill_op;

    ap_fetch_pkg::isa_word_t       prog_image [0:`AP_PROGRAM_DEPTH-1];
    ap_fetch_pkg::isa_word_t       isr_image [0:`AP_ISR_DEPTH-1];
    logic [31:0]                   rand_state;
    int                            error_count;
    int                            check_count;
    int                            test_count;
    int                            test_base;
    string                         test_name;
    int                            burst_count;
    logic [`AP_DDR_ADDR_WIDTH-1:0] burst_addr;
    logic [`AP_LEN_WIDTH-1:0]      burst_len;
    logic                          req_seen;

    ap_fetch_top i_dut (.*);

    ddr_isa_model i_ddr (.*);

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // Records each rising edge of the burst request.
    always @(negedge clk)
    begin
        if (isa_read_req && !req_seen)
        begin
            burst_count = burst_count + 1;
            burst_addr  = isa_read_addr;
            burst_len   = isa_read_len;
        end
        req_seen = isa_read_req;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic ap_fetch_pkg::isa_word_t next_word();
        rand_state = xorshift(rand_state);
        return rand_state[`AP_ISA_WIDTH-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input ap_fetch_pkg::isa_word_t exp,
                              input ap_fetch_pkg::isa_word_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input ap_fetch_pkg::op_class_t exp,
                               input ap_fetch_pkg::op_class_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driving and waiting.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ins_cache_rdy && n < load_timeout)
        begin
            n++;
            @(negedge clk);
        end
        if (!ins_cache_rdy)
        begin
            report_failure("ins_cache_rdy never returned high");
        end
    endtask

    task automatic issue_fetch(input logic [`AP_ADDR_WIDTH-1:0] a);
        wait_ready();
        @(posedge clk);
        #2;
        fetch    = 1'b1;
        addr_ins = a;
        @(posedge clk);
        #2;
        fetch    = 1'b0;
    endtask

    // Latency counts rising edges after the edge that sampled the fetch.
    task automatic wait_valid(input int limit, output int lat);
        lat = 0;
        @(negedge clk);
        while (!ins_valid && lat < limit)
        begin
            lat++;
            @(negedge clk);
        end
        if (!ins_valid)
        begin
            report_failure("ins_valid never came after a fetch");
        end
    endtask

    task automatic write_isr(input int idx, input ap_fetch_pkg::isa_word_t w);
        @(posedge clk);
        #2;
        isr_we    = 1'b1;
        isr_waddr = idx[`AP_ISR_ADDR_WIDTH-1:0];
        isr_wdata = w;
        isr_image[idx] = w;
        @(posedge clk);
        #2;
        isr_we    = 1'b0;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_base = error_count;
    endtask

    task automatic end_test();
        test_count++;
        if (error_count == test_base)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, error_count - test_base);
        end
    endtask

    task automatic check_hit(input string name, input logic [`AP_ADDR_WIDTH-1:0] a,
                             input ap_fetch_pkg::isa_word_t exp);
        int lat;
        issue_fetch(a);
        wait_valid(hit_timeout, lat);
        check_field({name, " latency"}, 2, lat);
        check_word({name, " word"}, exp, instruction);
    endtask

    // A miss loads a window based at a and cut at the program end.
    task automatic check_load(input string name, input int a, input int exp_loads);
        int lat;
        int bursts;
        int exp_len;
        exp_len = `AP_PROGRAM_DEPTH - a;
        if (exp_len > `AP_WINDOW_DEPTH)
        begin
            exp_len = `AP_WINDOW_DEPTH;
        end
        bursts = burst_count;
        issue_fetch(a[`AP_ADDR_WIDTH-1:0]);
        wait_valid(load_timeout, lat);
        check_field({name, " bursts"}, bursts + 1, burst_count);
        check_field({name, " read addr"}, a * `AP_WORD_BYTES, burst_addr);
        check_field({name, " read len"}, exp_len, burst_len);
        check_field({name, " req low"}, 0, isa_read_req);
        check_word({name, " word"}, prog_image[a], instruction);
        check_field({name, " load_times"}, exp_loads, load_times);
    endtask

    task automatic check_decode(input string name, input int idx,
                                input ap_fetch_pkg::op_class_t exp_class,
                                input logic [15:0] exp_mem, input logic [7:0] exp_src,
                                input logic [7:0] exp_cnt, input logic exp_ill);
        check_hit(name, 16'h8000 + idx[15:0], isr_image[idx]);
        check_class({name, " class"}, exp_class, op_class);
        check_field({name, " mem_addr"}, exp_mem, mem_addr);
        check_field({name, " src_row"}, exp_src, src_row);
        check_field({name, " count"}, exp_cnt, count);
        check_field({name, " ill_op"}, exp_ill, ill_op);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_first_load();
        begin_test("first_load");
        @(negedge clk);
        check_field("reset rdy", 1, ins_cache_rdy);
        check_field("reset req", 0, isa_read_req);
        check_field("reset ins_valid", 0, ins_valid);
        check_field("reset ill_op", 0, ill_op);
        check_load("fetch 5", 5, 1);
        end_test();
    endtask

    task automatic test_window_hits();
        int bursts;
        begin_test("window_hits");
        bursts = burst_count;
        for (int a = 6; a <= 132; a++)
        begin
            check_hit($sformatf("hit %0d", a), a[15:0], prog_image[a]);
        end
        check_field("hits bursts", bursts, burst_count);
        end_test();
    endtask

    task automatic test_reloads();
        begin_test("reloads");
        check_load("tail 250", 250, 2);
        check_load("refill 20", 20, 3);
        end_test();
    endtask

    task automatic test_isr_fetch();
        int bursts;
        begin_test("isr_fetch");
        for (int i = 0; i < `AP_ISR_DEPTH; i++)
        begin
            write_isr(i, next_word());
        end
        bursts = burst_count;
        for (int i = 0; i < `AP_ISR_DEPTH; i++)
        begin
            check_hit($sformatf("isr %0d", i), 16'h8000 + i[15:0], isr_image[i]);
        end
        check_field("isr bursts", bursts, burst_count);
        end_test();
    endtask

    task automatic test_decode();
        ap_fetch_pkg::isa_word_t w;
        begin_test("decode");
        w.mem.opcode   = ap_fetch_pkg::store_cbc;
        w.mem.cam_addr = 8'h5a;
        w.mem.mode     = ap_fetch_pkg::m_b;
        w.mem.mem_addr = 16'hbeef;
        write_isr(0, w);
        w.row.opcode   = ap_fetch_pkg::sub;
        w.row.cam_addr = 8'h21;
        w.row.mode     = ap_fetch_pkg::m_r;
        w.row.src_row  = 8'h3c;
        w.row.count    = 8'h11;
        write_isr(1, w);
        w.mem.opcode   = ap_fetch_pkg::ret;
        w.mem.cam_addr = 8'hff;
        w.mem.mode     = ap_fetch_pkg::m_a;
        w.mem.mem_addr = 16'h1234;
        write_isr(2, w);
        w = {4'hf, 26'h0012345};
        write_isr(3, w);
        check_decode("mem", 0, ap_fetch_pkg::mem_op, 16'hbeef, 8'h00, 8'h00, 1'b0);
        check_decode("row", 1, ap_fetch_pkg::row_op, 16'h0000, 8'h3c, 8'h11, 1'b0);
        check_decode("ctrl", 2, ap_fetch_pkg::ctrl_op, 16'h0000, 8'h00, 8'h00, 1'b0);
        check_decode("illegal", 3, ap_fetch_pkg::illegal_op, 16'h0000, 8'h00, 8'h00, 1'b1);
        end_test();
    endtask

    task automatic test_mid_reset();
        begin_test("mid_reset");
        pulse_reset();
        @(negedge clk);
        check_field("mid reset load_times", 0, load_times);
        check_field("mid reset rdy", 1, ins_cache_rdy);
        check_field("mid reset req", 0, isa_read_req);
        check_load("after reset 100", 100, 1);
        end_test();
    endtask

    initial
    begin
        rst         = 1'b0;
        fetch       = 1'b0;
        addr_ins    = '0;
        isr_we      = 1'b0;
        isr_waddr   = '0;
        isr_wdata   = '0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        burst_count = 0;
        burst_addr  = '0;
        burst_len   = '0;
        req_seen    = 1'b0;
        rand_state  = 32'h7424cfb0;
        for (int i = 0; i < `AP_PROGRAM_DEPTH; i++)
        begin
            prog_image[i]  = next_word();
            i_ddr.image[i] = prog_image[i];
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        test_first_load();
        test_window_hits();
        test_reloads();
        test_isr_fetch();
        test_decode();
        test_mid_reset();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: ap_fetch.f
+incdir+hw
hw/ap_fetch_pkg.sv
hw/ins_cache.sv
hw/isr_store.sv
hw/ins_issue.sv
hw/ap_fetch_top.sv
dv/ddr_isa_model.sv
dv/tb_ap_fetch.sv

// File: Bender.yml
package:
  name: ap_fetch

sources:
  - include_dirs:
      - hw
    files:
      - hw/ap_fetch_pkg.sv
      - hw/ins_cache.sv
      - hw/isr_store.sv
      - hw/ins_issue.sv
      - hw/ap_fetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/ddr_isa_model.sv
      - dv/tb_ap_fetch.sv
